// File: hw/ex_defs.svh
/*
 * execute unit constants: data widths, RV32 opcodes and funct3 codes
 */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define XLEN    32
`define SHAMT_W 5

// major opcodes handled by the unit
`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011

// OP / OP-IMM funct3
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// BRANCH funct3, 010 and 011 are reserved
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`endif

// File: hw/ex_isa_pkg.sv
/*
 * ISA-side types of the execute unit: data words, instruction fields
 * and the ALU, operand-select and branch-kind encodings
 */
`default_nettype none
`include "ex_defs.svh"

package ex_isa_pkg;

    typedef logic [`XLEN-1:0] word_t;     // data or address
    typedef logic [6:0]       opcode_t;
    typedef logic [2:0]       funct3_t;

    // encoding follows the core's ALU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SLL  = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_AND  = 4'd4,
        ALU_SRL  = 4'd5,
        ALU_SEQ  = 4'd6,
        ALU_SNE  = 4'd7,
        ALU_SUB  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_SLT  = 4'd10,
        ALU_SGE  = 4'd11,
        ALU_SLTU = 4'd12,
        ALU_SGEU = 4'd13
    } alu_op_e;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_e;

    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR, SRC_B_ZERO} src_b_e;

    typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JAL, BR_JALR} br_kind_e;

endpackage

`default_nettype wire

// File: hw/ex_ctrl_pkg.sv
/*
 * control types of the execute unit: handshake state and result register
 */
`default_nettype none

package ex_ctrl_pkg;

    typedef enum logic {
        HS_IDLE = 1'b0,
        HS_ACK  = 1'b1    // results held until req drops
    } hs_state_e;

    // everything returned to the requester in one register
    typedef struct packed {
        ex_isa_pkg::word_t result;
        logic              rd_we;
        ex_isa_pkg::word_t next_pc;
        logic              mispredict;
        logic              illegal;
    } res_reg_t;

endpackage

`default_nettype wire

// File: hw/ex_decode.sv
/*
 * instruction decode: opcode and funct fields to ALU operation,
 * operand selects, branch kind, rd write and illegal flag
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module ex_decode (
    input  wire ex_isa_pkg::opcode_t i_opcode,
    input  wire ex_isa_pkg::funct3_t i_funct3,
    input  wire logic                i_funct7_b5,
    output ex_isa_pkg::alu_op_e      o_alu_op,
    output ex_isa_pkg::src_a_e       o_src_a,
    output ex_isa_pkg::src_b_e       o_src_b,
    output ex_isa_pkg::br_kind_e     o_br_kind,
    output logic                     o_rd_we,
    output logic                     o_illegal
);
    import ex_isa_pkg::*;

    // OP and OP-IMM share funct3, only OP has SUB
    function automatic alu_op_e arith_op(funct3_t f3, logic alt, logic is_reg);
        alu_op_e op;
        case (f3)
            `F3_ADD:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            `F3_SLL:  op = ALU_SLL;
            `F3_SLT:  op = ALU_SLT;
            `F3_SLTU: op = ALU_SLTU;
            `F3_XOR:  op = ALU_XOR;
            `F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:   op = ALU_OR;
            default:  op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        o_alu_op  = ALU_ADD;    // illegal defaults, 0 + 0
        o_src_a   = SRC_A_ZERO;
        o_src_b   = SRC_B_ZERO;
        o_br_kind = BR_NONE;
        o_rd_we   = 1'b0;
        o_illegal = 1'b0;
        case (i_opcode)
            `OPC_OP: begin
                o_src_a  = SRC_A_RS1;
                o_src_b  = SRC_B_RS2;
                o_alu_op = arith_op(i_funct3, i_funct7_b5, 1'b1);
                o_rd_we  = 1'b1;
            end
            `OPC_OPIMM: begin
                o_src_a  = SRC_A_RS1;
                o_src_b  = SRC_B_IMM;
                o_alu_op = arith_op(i_funct3, i_funct7_b5, 1'b0);
                o_rd_we  = 1'b1;
            end
            `OPC_LUI: begin
                o_src_b = SRC_B_IMM;
                o_rd_we = 1'b1;
            end
            `OPC_AUIPC: begin
                o_src_a = SRC_A_PC;
                o_src_b = SRC_B_IMM;
                o_rd_we = 1'b1;
            end
            `OPC_JAL, `OPC_JALR: begin
                o_src_a   = SRC_A_PC;  // link value pc + 4
                o_src_b   = SRC_B_FOUR;
                o_br_kind = (i_opcode == `OPC_JAL) ? BR_JAL : BR_JALR;
                o_rd_we   = 1'b1;
            end
            `OPC_BRANCH: begin
                o_src_a   = SRC_A_RS1;
                o_src_b   = SRC_B_RS2;
                o_br_kind = BR_COND;
                case (i_funct3)
                    `F3_BEQ:  o_alu_op = ALU_SEQ;
                    `F3_BNE:  o_alu_op = ALU_SNE;
                    `F3_BLT:  o_alu_op = ALU_SLT;
                    `F3_BGE:  o_alu_op = ALU_SGE;
                    `F3_BLTU: o_alu_op = ALU_SLTU;
                    `F3_BGEU: o_alu_op = ALU_SGEU;
                    default: begin
                        o_src_a   = SRC_A_ZERO;
                        o_src_b   = SRC_B_ZERO;
                        o_br_kind = BR_NONE;    // falls through to pc + 4
                        o_illegal = 1'b1;
                    end
                endcase
            end
            default: o_illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/ex_alu.sv
/*
 * execute stage: operand A/B muxes and the fourteen-operation ALU
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module ex_alu (
    input  wire ex_isa_pkg::src_a_e  i_src_a,
    input  wire ex_isa_pkg::src_b_e  i_src_b,
    input  wire ex_isa_pkg::alu_op_e i_alu_op,
    input  wire ex_isa_pkg::word_t   i_rs1_val,
    input  wire ex_isa_pkg::word_t   i_rs2_val,
    input  wire ex_isa_pkg::word_t   i_pc,
    input  wire ex_isa_pkg::word_t   i_imm,
    output ex_isa_pkg::word_t        o_alu_out
);
    import ex_isa_pkg::*;

    word_t              op_a;
    word_t              op_b;
    logic [`SHAMT_W-1:0] shamt;

    always_comb begin
        case (i_src_a)
            SRC_A_RS1: op_a = i_rs1_val;
            SRC_A_PC:  op_a = i_pc;
            default:   op_a = '0;
        endcase
    end

    always_comb begin
        case (i_src_b)
            SRC_B_RS2:  op_b = i_rs2_val;
            SRC_B_IMM:  op_b = i_imm;
            SRC_B_FOUR: op_b = word_t'(4);
            default:    op_b = '0;
        endcase
    end

    assign shamt = op_b[`SHAMT_W-1:0]; // rs2 or imm, upper bits ignored

    // compares land in bit 0, branch reads it from there
    always_comb begin
        case (i_alu_op)
            ALU_ADD:  o_alu_out = op_a + op_b;
            ALU_SLL:  o_alu_out = op_a << shamt;
            ALU_XOR:  o_alu_out = op_a ^ op_b;
            ALU_OR:   o_alu_out = op_a | op_b;
            ALU_AND:  o_alu_out = op_a & op_b;
            ALU_SRL:  o_alu_out = op_a >> shamt;
            ALU_SEQ:  o_alu_out = word_t'(op_a == op_b);
            ALU_SNE:  o_alu_out = word_t'(op_a != op_b);
            ALU_SUB:  o_alu_out = op_a - op_b;
            ALU_SRA:  o_alu_out = word_t'($signed(op_a) >>> shamt);
            ALU_SLT:  o_alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SGE:  o_alu_out = word_t'($signed(op_a) >= $signed(op_b));
            ALU_SLTU: o_alu_out = word_t'(op_a < op_b);
            ALU_SGEU: o_alu_out = word_t'(op_a >= op_b);
            default:  o_alu_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/ex_branch.sv
/*
 * branch resolution: target, taken decision, next pc and the
 * compare against the predicted address
 */
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
    input  wire ex_isa_pkg::br_kind_e i_br_kind,
    input  wire ex_isa_pkg::word_t    i_alu_out,
    input  wire ex_isa_pkg::word_t    i_rs1_val,
    input  wire ex_isa_pkg::word_t    i_pc,
    input  wire ex_isa_pkg::word_t    i_imm,
    input  wire ex_isa_pkg::word_t    i_pred_addr,
    output ex_isa_pkg::word_t         o_next_pc,
    output logic                      o_mispredict
);
    import ex_isa_pkg::*;

    word_t target;
    word_t pc_plus4;
    logic  is_jump;
    logic  taken;

    assign is_jump = (i_br_kind == BR_JAL) || (i_br_kind == BR_JALR);

    // jalr keeps bit 0 of rs1 + imm
    assign target   = ((i_br_kind == BR_JALR) ? i_rs1_val : i_pc) + i_imm;
    assign pc_plus4 = i_pc + word_t'(4);

    assign taken = is_jump || ((i_br_kind == BR_COND) && i_alu_out[0]);

    assign o_next_pc    = taken ? target : pc_plus4;
    assign o_mispredict = (o_next_pc != i_pred_addr);

endmodule

`default_nettype wire

// File: hw/ex_result.sv
/*
 * result stage with the four-phase req/ack FSM that captures the
 * results on the IDLE to ACK edge and holds them for the requester
 */
`timescale 1ns/1ps
`default_nettype none

module ex_result (
    input  wire logic              i_clk,
    input  wire logic              i_resetn,
    input  wire logic              i_req,
    input  wire ex_isa_pkg::word_t i_result,
    input  wire logic              i_rd_we,
    input  wire logic              i_illegal,
    input  wire ex_isa_pkg::word_t i_next_pc,
    input  wire logic              i_mispredict,
    output logic                   o_ack,
    output ex_isa_pkg::word_t      o_result,
    output logic                   o_rd_we,
    output ex_isa_pkg::word_t      o_next_pc,
    output logic                   o_mispredict,
    output logic                   o_illegal
);
    import ex_ctrl_pkg::*;

    hs_state_e state;
    res_reg_t  res_q;
    logic      capture;

    assign capture = (state == HS_IDLE) && i_req;

    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE: if (i_req) state <= HS_ACK;
                HS_ACK:  if (!i_req) state <= HS_IDLE;
                default: state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            res_q <= '0;
        end else if (capture) begin
            res_q.result     <= i_result;
            res_q.rd_we      <= i_rd_we;
            res_q.next_pc    <= i_next_pc;
            res_q.mispredict <= i_mispredict;
            res_q.illegal    <= i_illegal;
        end
    end

    assign o_ack        = (state == HS_ACK);
    assign o_result     = res_q.result;
    assign o_rd_we      = res_q.rd_we;
    assign o_next_pc    = res_q.next_pc;
    assign o_mispredict = res_q.mispredict;
    assign o_illegal    = res_q.illegal;

    // ack only answers a request seen on the previous edge
    a_ack_after_req: assert property (
        @(posedge i_clk) disable iff (!i_resetn)
        $rose(o_ack) |-> $past(i_req)
    );

    a_hold_stable: assert property (
        @(posedge i_clk) disable iff (!i_resetn)
        o_ack |=> $stable(res_q)
    );

    // decode never marks an illegal instruction as writing rd
    a_we_not_illegal: assert property (
        @(posedge i_clk) disable iff (!i_resetn)
        capture |-> !(i_rd_we && i_illegal)
    );

endmodule

`default_nettype wire

// File: hw/ex_unit.sv
/*
 * integer execute unit top: decode, execute, branch and result stage
 */
`timescale 1ns/1ps
`default_nettype none

module ex_unit (
    input  wire logic                i_clk,
    input  wire logic                i_resetn,
    input  wire logic                i_req,
    input  wire ex_isa_pkg::opcode_t i_opcode,
    input  wire ex_isa_pkg::funct3_t i_funct3,
    input  wire logic                i_funct7_b5,
    input  wire ex_isa_pkg::word_t   i_rs1_val,
    input  wire ex_isa_pkg::word_t   i_rs2_val,
    input  wire ex_isa_pkg::word_t   i_pc,
    input  wire ex_isa_pkg::word_t   i_imm,
    input  wire ex_isa_pkg::word_t   i_pred_addr,
    output wire logic                o_ack,
    output wire ex_isa_pkg::word_t   o_result,
    output wire logic                o_rd_we,
    output wire ex_isa_pkg::word_t   o_next_pc,
    output wire logic                o_mispredict,
    output wire logic                o_illegal
);
    import ex_isa_pkg::*;

    alu_op_e  alu_op;
    src_a_e   src_a;
    src_b_e   src_b;
    br_kind_e br_kind;
    logic     rd_we;
    logic     illegal;
    word_t    alu_out;
    word_t    next_pc;
    logic     mispredict;

    ex_decode u_decode (
        .i_opcode   (i_opcode),
        .i_funct3   (i_funct3),
        .i_funct7_b5(i_funct7_b5),
        .o_alu_op   (alu_op),
        .o_src_a    (src_a),
        .o_src_b    (src_b),
        .o_br_kind  (br_kind),
        .o_rd_we    (rd_we),
        .o_illegal  (illegal)
    );

    ex_alu u_alu (
        .i_src_a  (src_a),
        .i_src_b  (src_b),
        .i_alu_op (alu_op),
        .i_rs1_val(i_rs1_val),
        .i_rs2_val(i_rs2_val),
        .i_pc     (i_pc),
        .i_imm    (i_imm),
        .o_alu_out(alu_out)
    );

    ex_branch u_branch (
        .i_br_kind   (br_kind),
        .i_alu_out   (alu_out),     // bit 0 is the compare
        .i_rs1_val   (i_rs1_val),
        .i_pc        (i_pc),
        .i_imm       (i_imm),
        .i_pred_addr (i_pred_addr),
        .o_next_pc   (next_pc),
        .o_mispredict(mispredict)
    );

    ex_result u_result (
        .i_clk       (i_clk),
        .i_resetn    (i_resetn),
        .i_req       (i_req),
        .i_result    (alu_out),
        .i_rd_we     (rd_we),
        .i_illegal   (illegal),
        .i_next_pc   (next_pc),
        .i_mispredict(mispredict),
        .o_ack       (o_ack),
        .o_result    (o_result),
        .o_rd_we     (o_rd_we),
        .o_next_pc   (o_next_pc),
        .o_mispredict(o_mispredict),
        .o_illegal   (o_illegal)
    );

endmodule

`default_nettype wire

// File: tb/ex_checker.sv
/*
 * execute unit scoreboard with a reference model of the RV32 rules
 * that checks the DUT outputs on every handshake
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module ex_checker (
    input  wire logic                i_clk,
    input  wire logic                i_resetn,
    input  wire logic                i_req,
    input  wire ex_isa_pkg::opcode_t i_opcode,
    input  wire ex_isa_pkg::funct3_t i_funct3,
    input  wire logic                i_funct7_b5,
    input  wire ex_isa_pkg::word_t   i_rs1_val,
    input  wire ex_isa_pkg::word_t   i_rs2_val,
    input  wire ex_isa_pkg::word_t   i_pc,
    input  wire ex_isa_pkg::word_t   i_imm,
    input  wire ex_isa_pkg::word_t   i_pred_addr,
    input  wire logic                i_ack,
    input  wire ex_isa_pkg::word_t   i_result,
    input  wire logic                i_rd_we,
    input  wire ex_isa_pkg::word_t   i_next_pc,
    input  wire logic                i_mispredict,
    input  wire logic                i_illegal,
    output ex_isa_pkg::word_t        o_model_next_pc,
    output int                       o_value_errors,
    output int                       o_hs_errors,
    output int                       o_checked
);
    import ex_isa_pkg::*;

    logic [66:0] outs;
    logic [66:0] held;
    logic        exp_ack = 1'b0;
    logic        first_ack = 1'b0;
    logic        in_reset = 1'b0;
    word_t       exp_result;
    word_t       exp_next_pc;
    logic        exp_rd_we;
    logic        exp_misp;
    logic        exp_illegal;

    function automatic logic is_illegal(opcode_t opc, funct3_t f3);
        case (opc)
            7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111,
            7'b1101111, 7'b1100111: return 1'b0;
            7'b1100011: return (f3 == 3'b010) || (f3 == 3'b011);
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic cond_holds(funct3_t f3, word_t a, word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t model_next_pc(opcode_t opc, funct3_t f3, word_t rs1,
                                            word_t rs2, word_t pc, word_t imm);
        if (is_illegal(opc, f3))
            return pc + 4;
        case (opc)
            `OPC_JAL:    return pc + imm;
            `OPC_JALR:   return rs1 + imm;    // bit 0 not cleared
            `OPC_BRANCH: return cond_holds(f3, rs1, rs2) ? pc + imm : pc + 4;
            default:     return pc + 4;
        endcase
    endfunction

    function automatic word_t model_result(opcode_t opc, funct3_t f3, logic alt, word_t rs1,
                                           word_t rs2, word_t pc, word_t imm);
        word_t              b;
        logic signed [31:0] sa;
        b  = (opc == `OPC_OP) ? rs2 : imm;
        sa = rs1;
        if (is_illegal(opc, f3))
            return '0;
        case (opc)
            `OPC_LUI:            return imm;
            `OPC_AUIPC:          return pc + imm;
            `OPC_JAL, `OPC_JALR: return pc + 4;
            `OPC_BRANCH:         return word_t'(cond_holds(f3, rs1, rs2));
            default: ;
        endcase
        case (f3)    // OP and OP-IMM
            3'b000:  return (alt && opc == `OPC_OP) ? rs1 - b : rs1 + b;
            3'b001:  return rs1 << b[4:0];
            3'b010:  return word_t'($signed(rs1) < $signed(b));
            3'b011:  return word_t'(rs1 < b);
            3'b100:  return rs1 ^ b;
            3'b101:  return alt ? word_t'(sa >>> b[4:0]) : rs1 >> b[4:0];
            3'b110:  return rs1 | b;
            default: return rs1 & b;
        endcase
    endfunction

    task automatic compare_value(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h, got %h", name, exp, act);
            o_value_errors++;
        end
    endtask

    assign outs = {i_result, i_rd_we, i_next_pc, i_mispredict, i_illegal};
    assign o_model_next_pc = model_next_pc(i_opcode, i_funct3, i_rs1_val, i_rs2_val,
                                           i_pc, i_imm);

    // samples the pre-edge values of the registered outputs
    always @(posedge i_clk) begin
        if (!i_resetn) begin
            exp_ack  = 1'b0;
            in_reset = 1'b1;
        end else begin
            if (in_reset && (outs !== '0 || i_ack !== 1'b0)) begin
                $display("reset did not clear o_ack and the result outputs at %0t", $time);
                o_hs_errors++;
            end
            in_reset = 1'b0;
            if (i_ack !== exp_ack) begin
                $display("o_ack is %b at %0t where the handshake needs %b", i_ack, $time, exp_ack);
                o_hs_errors++;
            end else if (exp_ack && first_ack) begin
                compare_value("o_result", exp_result, i_result);
                compare_value("o_rd_we", exp_rd_we, i_rd_we);
                compare_value("o_next_pc", exp_next_pc, i_next_pc);
                compare_value("o_mispredict", exp_misp, i_mispredict);
                compare_value("o_illegal", exp_illegal, i_illegal);
                held      = outs;
                first_ack = 1'b0;
                o_checked++;
            end else if (exp_ack && outs !== held) begin
                $display("result outputs changed at %0t while o_ack was held", $time);
                o_hs_errors++;
            end
            if (!exp_ack && i_req) begin    // request taken at this edge
                exp_result  = model_result(i_opcode, i_funct3, i_funct7_b5, i_rs1_val,
                                           i_rs2_val, i_pc, i_imm);
                exp_next_pc = model_next_pc(i_opcode, i_funct3, i_rs1_val, i_rs2_val,
                                            i_pc, i_imm);
                exp_illegal = is_illegal(i_opcode, i_funct3);
                exp_rd_we   = !exp_illegal && (i_opcode != `OPC_BRANCH);
                exp_misp    = (exp_next_pc != i_pred_addr);
                exp_ack     = 1'b1;
                first_ack   = 1'b1;
            end else if (exp_ack && !i_req) begin
                exp_ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_ex_unit.sv
/*
 * execute unit testbench: clock, reset, seeded random requester with
 * back-pressure, run-time watchdog and the scoreboard
 */
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module tb_ex_unit;
    import ex_isa_pkg::*;

    localparam int NUM_TXN = 400;
    localparam int PERIOD  = 40;

    logic    clk;
    logic    resetn;
    logic    req;
    opcode_t opcode;
    funct3_t funct3;
    logic    funct7_b5;
    word_t   rs1_val;
    word_t   rs2_val;
    word_t   pc;
    word_t   imm;
    word_t   pred_addr;
    wire     ack;
    word_t   result;
    wire     rd_we;
    word_t   next_pc;
    wire     mispredict;
    wire     illegal;
    word_t   model_pc;
    int      value_errors;
    int      hs_errors;
    int      checked;
    integer  seed = 50;

    ex_unit i_ex_unit (
        .i_clk(clk), .i_resetn(resetn), .i_req(req),
        .i_opcode(opcode), .i_funct3(funct3), .i_funct7_b5(funct7_b5),
        .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .i_pc(pc), .i_imm(imm),
        .i_pred_addr(pred_addr), .o_ack(ack), .o_result(result), .o_rd_we(rd_we),
        .o_next_pc(next_pc), .o_mispredict(mispredict), .o_illegal(illegal)
    );

    ex_checker i_ex_checker (
        .i_clk(clk), .i_resetn(resetn), .i_req(req),
        .i_opcode(opcode), .i_funct3(funct3), .i_funct7_b5(funct7_b5),
        .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .i_pc(pc), .i_imm(imm),
        .i_pred_addr(pred_addr), .i_ack(ack), .i_result(result), .i_rd_we(rd_we),
        .i_next_pc(next_pc), .i_mispredict(mispredict), .i_illegal(illegal),
        .o_model_next_pc(model_pc), .o_value_errors(value_errors),
        .o_hs_errors(hs_errors), .o_checked(checked)
    );

    task automatic pick_fields();
        int cls;
        cls = {$random(seed)} % 16;
        case (cls)
            0, 1, 2:    opcode = `OPC_OP;
            3, 4, 5:    opcode = `OPC_OPIMM;
            6:          opcode = `OPC_LUI;
            7:          opcode = `OPC_AUIPC;
            8:          opcode = `OPC_JAL;
            9:          opcode = `OPC_JALR;
            15:         opcode = {5'($random(seed)), 2'({$random(seed)} % 3)}; // low bits != 11
            default:    opcode = `OPC_BRANCH;
        endcase
        funct3    = funct3_t'($random(seed));
        funct7_b5 = 1'($random(seed));
        rs1_val   = $random(seed);
        rs2_val   = ({$random(seed)} % 4 == 0) ? rs1_val : word_t'($random(seed));
        imm       = $random(seed);
        pc        = {30'($random(seed)), 2'b00};
    endtask

    task automatic run_handshake();
        int extra;
        pick_fields();
        @(negedge clk);
        pred_addr = ({$random(seed)} % 2 == 0) ? model_pc : word_t'($random(seed));
        req = 1'b1;
        @(negedge clk);
        while (!ack) @(negedge clk);
        extra = {$random(seed)} % 4;
        repeat (extra) begin
            rs1_val = $random(seed);    // fields free once ack is seen
            imm     = $random(seed);
            @(negedge clk);
        end
        req = 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TXN * 12 * PERIOD);
        $display("watchdog expired after %0d cycles, the handshakes did not finish", NUM_TXN * 12);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        resetn = 1'b0;
        req = 1'b0;
        opcode = '0;
        funct3 = '0;
        funct7_b5 = 1'b0;
        rs1_val = '0;
        rs2_val = '0;
        pc = '0;
        imm = '0;
        pred_addr = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        repeat (NUM_TXN) run_handshake();
        repeat (2) @(negedge clk);
        if (checked != NUM_TXN)
            $display("scoreboard compared %0d handshakes instead of %0d", checked, NUM_TXN);
        $display("handshakes: %0d, value errors: %0d, handshake errors: %0d",
                 checked, value_errors, hs_errors);
        if (value_errors == 0 && hs_errors == 0 && checked == NUM_TXN) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ex_unit.f
+incdir+hw
hw/ex_isa_pkg.sv
hw/ex_ctrl_pkg.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_result.sv
hw/ex_unit.sv
tb/ex_checker.sv
tb/tb_ex_unit.sv
